// File: verilog.f
src/rvv_pkg.sv
src/lane_pkg.sv
src/valu_simd_alu.sv
src/valu_insn_queue.sv
src/valu_issue.sv
src/valu_result_queue.sv
src/valu_top.sv
dv/tb_clk_gen.sv
dv/tb_valu.sv

// File: Makefile
# Verilator build and run of the vector ALU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module tb_valu -Mdir obj_dir -f verilog.f

# The log decides pass or fail
run: compile
	./obj_dir/Vtb_valu | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_valu.sv
module tb_valu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumInsn   = 200;
  localparam int IdleLimit = 500;

  // Accepted instruction as the model sees it
  typedef struct packed {
    rvv_pkg::alu_op_e op;
    rvv_pkg::vew_e    vsew;
    lane_pkg::vlen_t  vl;
    lane_pkg::vreg_t  vd;
    rvv_pkg::vid_t    id;
    logic             vm;
    logic             use_scalar;
    lane_pkg::elen_t  scalar;
  } insn_t;

  // One expected register file write
  typedef struct packed {
    rvv_pkg::vid_t    id;
    lane_pkg::vaddr_t addr;
    lane_pkg::elen_t  wdata;
    lane_pkg::strb_t  be;
    logic             last;
  } word_t;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic             insn_valid;
  rvv_pkg::alu_op_e insn_op;
  rvv_pkg::vew_e    insn_vsew;
  lane_pkg::vlen_t  insn_vl;
  lane_pkg::vreg_t  insn_vd;
  rvv_pkg::vid_t    insn_id;
  logic             insn_vm;
  logic             insn_use_scalar;
  lane_pkg::elen_t  insn_scalar;
  lane_pkg::elen_t  operand_a;
  lane_pkg::elen_t  operand_b;
  logic [1:0]       operand_valid;
  lane_pkg::strb_t  mask;
  logic             mask_valid;
  logic             result_gnt;
  // DUT outputs
  logic                        insn_ready;
  logic [rvv_pkg::NrVInsn-1:0] insn_done;
  logic [1:0]                  operand_ready;
  logic                        mask_ready;
  logic                        result_req;
  rvv_pkg::vid_t               result_id;
  lane_pkg::vaddr_t            result_addr;
  lane_pkg::elen_t             result_wdata;
  lane_pkg::strb_t             result_be;

  // Model state
  int            seed = 57;
  insn_t         issue_q[$];
  word_t         word_q[$];
  // Ids in the order their done pulses are due
  rvv_pkg::vid_t done_q[$];
  int            sent;
  int            accepted;
  int            retired;
  int            issued_elems;
  int            saw_full;
  int            cycle;
  int            idle;
  logic          insn_taken;
  logic          a_taken;
  logic          b_taken;
  logic          mask_taken;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  valu_top valu_top_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .insn_valid_i      (insn_valid),
    .insn_ready_o      (insn_ready),
    .insn_op_i         (insn_op),
    .insn_vsew_i       (insn_vsew),
    .insn_vl_i         (insn_vl),
    .insn_vd_i         (insn_vd),
    .insn_id_i         (insn_id),
    .insn_vm_i         (insn_vm),
    .insn_use_scalar_i (insn_use_scalar),
    .insn_scalar_i     (insn_scalar),
    .insn_done_o       (insn_done),
    .operand_a_i       (operand_a),
    .operand_b_i       (operand_b),
    .operand_valid_i   (operand_valid),
    .operand_ready_o   (operand_ready),
    .mask_i            (mask),
    .mask_valid_i      (mask_valid),
    .mask_ready_o      (mask_ready),
    .result_req_o      (result_req),
    .result_id_o       (result_id),
    .result_addr_o     (result_addr),
    .result_wdata_o    (result_wdata),
    .result_be_o       (result_be),
    .result_gnt_i      (result_gnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] draw_random();
    draw_random = $random(seed);
  endfunction

  // Low element of the scalar in every slot
  function automatic logic [63:0] replicate(logic [63:0] s, int bits);
    logic [63:0] m;
    logic [63:0] res;
    m   = (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
    res = '0;
    for (int i = 0; i < 64 / bits; i++) begin
      res = res | ((s & m) << (i * bits));
    end
    return res;
  endfunction

  // Elementwise vs2 op vs1 with each element cut to its own width
  function automatic logic [63:0] simd_expect(logic [63:0] a, logic [63:0] b,
                                              rvv_pkg::alu_op_e op, int bits);
    logic [63:0] m;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] r;
    logic [63:0] res;
    m   = (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
    res = '0;
    for (int i = 0; i < 64 / bits; i++) begin
      ea = (a >> (i * bits)) & m;
      eb = (b >> (i * bits)) & m;
      case (op)
        rvv_pkg::VADD:  r = eb + ea;
        rvv_pkg::VSUB:  r = eb - ea;
        rvv_pkg::VRSUB: r = ea - eb;
        rvv_pkg::VAND:  r = eb & ea;
        rvv_pkg::VOR:   r = eb | ea;
        rvv_pkg::VXOR:  r = eb ^ ea;
        rvv_pkg::VMINU: r = (eb < ea) ? eb : ea;
        default:        r = (eb > ea) ? eb : ea;
      endcase
      res = res | ((r & m) << (i * bits));
    end
    return res;
  endfunction

  function automatic logic [63:0] byte_mask(lane_pkg::strb_t be);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = be[b] ? 8'hff : 8'h00;
    end
    return m;
  endfunction

  // Builds the word that the current operands produce for the head instruction
  task automatic push_expected(insn_t ins);
    int    bits;
    int    epw;
    int    rem;
    int    cnt;
    word_t w;
    bits  = 8 << ins.vsew;
    epw   = 64 / bits;
    rem   = int'(ins.vl) - issued_elems;
    cnt   = (rem < epw) ? rem : epw;
    w.id  = ins.id;
    w.addr = lane_pkg::vaddr_t'(int'(ins.vd) * int'(lane_pkg::VRegWords)
                                + issued_elems / epw);
    w.wdata = simd_expect(ins.use_scalar ? replicate(ins.scalar, bits) : operand_a,
                          operand_b, ins.op, bits);
    for (int b = 0; b < 8; b++) begin
      w.be[b] = ((b / (bits / 8)) < cnt) && (ins.vm || mask[b]);
    end
    w.last = rem == cnt;
    word_q.push_back(w);
    issued_elems += cnt;
    if (w.last) begin
      void'(issue_q.pop_front());
      issued_elems = 0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Opcode and width step through every pair while other fields are random
  task automatic new_insn();
    logic [31:0] r;
    r               = draw_random();
    insn_op         = rvv_pkg::alu_op_e'(3'(sent));
    insn_vsew       = rvv_pkg::vew_e'(2'(sent / 8));
    insn_vl         = lane_pkg::vlen_t'(r[4:0]) + lane_pkg::vlen_t'(1);
    insn_vd         = r[9:5];
    insn_id         = rvv_pkg::vid_t'(sent);
    insn_vm         = r[10];
    insn_use_scalar = r[12:11] == 2'd0;
    insn_scalar     = {draw_random(), draw_random()};
    insn_valid      = 1'b1;
    sent++;
  endtask

  // Valid stays up until the word is taken
  task automatic drive_inputs();
    logic [31:0] r;
    int          mode;
    r = draw_random();
    if (insn_taken) begin
      insn_valid = 1'b0;
      insn_taken = 1'b0;
    end
    if (!insn_valid && sent < NumInsn && r[1:0] != 2'd0) new_insn();
    if (b_taken || !operand_valid[1]) begin
      operand_b        = {draw_random(), draw_random()};
      operand_valid[1] = r[2] | r[3];
      b_taken          = 1'b0;
    end
    if (a_taken || !operand_valid[0]) begin
      operand_a        = {draw_random(), draw_random()};
      operand_valid[0] = r[4] | r[5];
      a_taken          = 1'b0;
    end
    if (mask_taken || !mask_valid) begin
      mask       = lane_pkg::strb_t'(draw_random());
      mask_valid = r[6] | r[7];
      mask_taken = 1'b0;
    end
    // Grant rate changes every 64 cycles so that slow phases fill the queues
    mode = (cycle / 64) % 4;
    case (mode)
      0:       result_gnt = 1'b1;
      1:       result_gnt = r[8];
      2:       result_gnt = r[10:8] == 3'd0;
      default: result_gnt = r[9:8] != 2'd0;
    endcase
  endtask

  // Compares the DUT with the model and applies this cycle's transfers
  task automatic sample_cycle();
    insn_t       head;
    word_t       w;
    logic        exp_fire;
    logic        exp_ready;
    logic [63:0] exp_done;
    logic [63:0] bm;
    head = '0;
    if (issue_q.size() != 0) head = issue_q[0];
    exp_ready = (accepted - retired) < int'(lane_pkg::InsnQueueDepth);
    check_value("insn_ready_o", 64'(insn_ready), 64'(exp_ready));
    if (!insn_ready) saw_full++;

    // Operand and mask handshake
    exp_fire = issue_q.size() != 0 && word_q.size() < int'(lane_pkg::ResultQueueDepth)
            && operand_valid[1] && (operand_valid[0] || head.use_scalar)
            && (mask_valid || head.vm);
    check_value("operand_ready_o", 64'(operand_ready),
                64'({exp_fire, exp_fire & ~head.use_scalar}));
    check_value("mask_ready_o", 64'(mask_ready), 64'(exp_fire & ~head.vm));

    // Register file port against the oldest expected word
    check_value("result_req_o", 64'(result_req), 64'(word_q.size() != 0));
    exp_done = '0;
    if (word_q.size() != 0) begin
      w  = word_q[0];
      bm = byte_mask(w.be);
      check_value("result_id_o", 64'(result_id), 64'(w.id));
      check_value("result_addr_o", 64'(result_addr), 64'(w.addr));
      check_value("result_be_o", 64'(result_be), 64'(w.be));
      check_value("result_wdata_o", result_wdata & bm, w.wdata & bm);
      if (result_gnt) begin
        idle = 0;
        void'(word_q.pop_front());
        if (w.last) begin
          exp_done = 64'd1 << done_q[0];
          void'(done_q.pop_front());
          retired++;
        end
      end
    end
    check_value("insn_done_o", 64'(insn_done), exp_done);

    if (exp_fire) begin
      push_expected(head);
      b_taken = 1'b1;
      if (!head.use_scalar) a_taken = 1'b1;
      if (!head.vm) mask_taken = 1'b1;
    end

    if (insn_valid && insn_ready) begin
      issue_q.push_back({insn_op, insn_vsew, insn_vl, insn_vd, insn_id, insn_vm,
                         insn_use_scalar, insn_scalar});
      done_q.push_back(insn_id);
      accepted++;
      insn_taken = 1'b1;
      idle       = 0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int t;
    insn_valid      = 1'b0;
    insn_op         = rvv_pkg::VADD;
    insn_vsew       = rvv_pkg::EW8;
    insn_vl         = '0;
    insn_vd         = '0;
    insn_id         = '0;
    insn_vm         = 1'b0;
    insn_use_scalar = 1'b0;
    insn_scalar     = '0;
    operand_a       = '0;
    operand_b       = '0;
    operand_valid   = 2'b00;
    mask            = '0;
    mask_valid      = 1'b0;
    result_gnt      = 1'b0;
    insn_taken      = 1'b0;
    a_taken         = 1'b0;
    b_taken         = 1'b0;
    mask_taken      = 1'b0;
    sent            = 0;
    accepted        = 0;
    retired         = 0;
    issued_elems    = 0;
    saw_full        = 0;
    cycle           = 0;
    idle            = 0;

    t = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > 20) abort_run("Reset was never released");
    end

    // Offered operands stay untaken while no instruction is queued
    @(negedge clk);
    operand_a     = {draw_random(), draw_random()};
    operand_b     = {draw_random(), draw_random()};
    mask          = lane_pkg::strb_t'(draw_random());
    operand_valid = 2'b11;
    mask_valid    = 1'b1;
    #1;
    check_value("insn_ready_o", 64'(insn_ready), 64'd1);
    check_value("result_req_o", 64'(result_req), 64'd0);
    check_value("insn_done_o", 64'(insn_done), 64'd0);
    check_value("operand_ready_o", 64'(operand_ready), 64'd0);
    check_value("mask_ready_o", 64'(mask_ready), 64'd0);

    while (retired < NumInsn) begin
      @(negedge clk);
      drive_inputs();
      #1;
      sample_cycle();
      cycle++;
      idle++;
      if (idle > IdleLimit) abort_run("Timeout with no instruction accepted or word granted");
    end

    if (saw_full == 0) begin
      abort_run("The instruction queue never filled, insn_ready_o was never low");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Hold reset for 4 cycles, release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: src/valu_top.sv
module valu_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Instructions from the sequencer
  input  logic                        insn_valid_i,
  output logic                        insn_ready_o,
  input  rvv_pkg::alu_op_e            insn_op_i,
  input  rvv_pkg::vew_e               insn_vsew_i,
  input  lane_pkg::vlen_t             insn_vl_i,
  input  lane_pkg::vreg_t             insn_vd_i,
  input  rvv_pkg::vid_t               insn_id_i,
  input  logic                        insn_vm_i,
  input  logic                        insn_use_scalar_i,
  input  lane_pkg::elen_t             insn_scalar_i,
  output logic [rvv_pkg::NrVInsn-1:0] insn_done_o,
  // Operand and mask queues
  input  lane_pkg::elen_t             operand_a_i,
  input  lane_pkg::elen_t             operand_b_i,
  input  logic [1:0]                  operand_valid_i,
  output logic [1:0]                  operand_ready_o,
  input  lane_pkg::strb_t             mask_i,
  input  logic                        mask_valid_i,
  output logic                        mask_ready_o,
  // Register file write port
  output logic                        result_req_o,
  output rvv_pkg::vid_t               result_id_o,
  output lane_pkg::vaddr_t            result_addr_o,
  output lane_pkg::elen_t             result_wdata_o,
  output lane_pkg::strb_t             result_be_o,
  input  logic                        result_gnt_i
);

  // Issue instruction
  logic             issue_valid;
  rvv_pkg::alu_op_e issue_op;
  rvv_pkg::vew_e    issue_vsew;
  lane_pkg::vlen_t  issue_vl;
  lane_pkg::vreg_t  issue_vd;
  rvv_pkg::vid_t    issue_id;
  logic             issue_vm;
  logic             issue_use_scalar;
  lane_pkg::elen_t  issue_scalar;
  logic             issue_done;
  // Commit instruction
  logic             commit_valid;
  rvv_pkg::vid_t    commit_id;
  lane_pkg::vlen_t  commit_vl;
  rvv_pkg::vew_e    commit_vsew;
  logic             commit_done;
  // Result queue write
  logic             rq_full;
  logic             rq_push;
  rvv_pkg::vid_t    rq_id;
  lane_pkg::vaddr_t rq_addr;
  lane_pkg::elen_t  rq_wdata;
  lane_pkg::strb_t  rq_be;

  // External ports connect by name
  valu_insn_queue i_insn_queue (
    .*,
    .issue_valid_o      (issue_valid),
    .issue_op_o         (issue_op),
    .issue_vsew_o       (issue_vsew),
    .issue_vl_o         (issue_vl),
    .issue_vd_o         (issue_vd),
    .issue_id_o         (issue_id),
    .issue_vm_o         (issue_vm),
    .issue_use_scalar_o (issue_use_scalar),
    .issue_scalar_o     (issue_scalar),
    .issue_done_i       (issue_done),
    .commit_valid_o     (commit_valid),
    .commit_id_o        (commit_id),
    .commit_vl_o        (commit_vl),
    .commit_vsew_o      (commit_vsew),
    .commit_done_i      (commit_done)
  );

  valu_issue i_issue (
    .*,
    .issue_valid_i      (issue_valid),
    .issue_op_i         (issue_op),
    .issue_vsew_i       (issue_vsew),
    .issue_vl_i         (issue_vl),
    .issue_vd_i         (issue_vd),
    .issue_id_i         (issue_id),
    .issue_vm_i         (issue_vm),
    .issue_use_scalar_i (issue_use_scalar),
    .issue_scalar_i     (issue_scalar),
    .issue_done_o       (issue_done),
    .rq_full_i          (rq_full),
    .rq_push_o          (rq_push),
    .rq_id_o            (rq_id),
    .rq_addr_o          (rq_addr),
    .rq_wdata_o         (rq_wdata),
    .rq_be_o            (rq_be)
  );

  valu_result_queue i_result_queue (
    .*,
    .rq_push_i      (rq_push),
    .rq_id_i        (rq_id),
    .rq_addr_i      (rq_addr),
    .rq_wdata_i     (rq_wdata),
    .rq_be_i        (rq_be),
    .rq_full_o      (rq_full),
    .commit_valid_i (commit_valid),
    .commit_id_i    (commit_id),
    .commit_vl_i    (commit_vl),
    .commit_vsew_i  (commit_vsew),
    .commit_done_o  (commit_done)
  );

endmodule

// File: src/valu_result_queue.sv
module valu_result_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Write side
  input  logic                        rq_push_i,
  input  rvv_pkg::vid_t               rq_id_i,
  input  lane_pkg::vaddr_t            rq_addr_i,
  input  lane_pkg::elen_t             rq_wdata_i,
  input  lane_pkg::strb_t             rq_be_i,
  output logic                        rq_full_o,
  // Commit instruction
  input  logic                        commit_valid_i,
  input  rvv_pkg::vid_t               commit_id_i,
  input  lane_pkg::vlen_t             commit_vl_i,
  input  rvv_pkg::vew_e               commit_vsew_i,
  output logic                        commit_done_o,
  // Register file port
  output logic                        result_req_o,
  output rvv_pkg::vid_t               result_id_o,
  output lane_pkg::vaddr_t            result_addr_o,
  output lane_pkg::elen_t             result_wdata_o,
  output lane_pkg::strb_t             result_be_o,
  input  logic                        result_gnt_i,
  output logic [rvv_pkg::NrVInsn-1:0] insn_done_o
);

  // Payload slots
  rvv_pkg::vid_t    id_q    [lane_pkg::ResultQueueDepth];
  lane_pkg::vaddr_t addr_q  [lane_pkg::ResultQueueDepth];
  lane_pkg::elen_t  wdata_q [lane_pkg::ResultQueueDepth];
  lane_pkg::strb_t  be_q    [lane_pkg::ResultQueueDepth];

  lane_pkg::rq_pnt_t wr_pnt_q, rd_pnt_q;
  lane_pkg::rq_cnt_t cnt_q;
  logic              gnt;

  // Elements of the commit instruction still to be written
  logic              loaded_q;
  lane_pkg::vlen_t   rem_q;
  lane_pkg::vlen_t   remaining;
  lane_pkg::vlen_t   elem_per_word;
  lane_pkg::vlen_t   rem_next;

  //////////////////////////////////////////////////////////////////////////
  // FIFO
  //////////////////////////////////////////////////////////////////////////

  assign rq_full_o      = cnt_q == lane_pkg::rq_cnt_t'(lane_pkg::ResultQueueDepth);
  assign result_req_o   = cnt_q != '0;
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];
  // Grant only counts against a pending request
  assign gnt            = result_req_o & result_gnt_i;

  always_ff @(posedge clk_i) begin
    if (rq_push_i) begin
      id_q[wr_pnt_q]    <= rq_id_i;
      addr_q[wr_pnt_q]  <= rq_addr_i;
      wdata_q[wr_pnt_q] <= rq_wdata_i;
      be_q[wr_pnt_q]    <= rq_be_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Commit counting
  //////////////////////////////////////////////////////////////////////////

  assign remaining     = loaded_q ? rem_q : commit_vl_i;
  assign elem_per_word = lane_pkg::vlen_t'(1) << (2'd3 - commit_vsew_i);
  // Tail word may carry fewer elements than a full word
  assign rem_next      = (remaining > elem_per_word) ? remaining - elem_per_word : '0;
  assign commit_done_o = gnt & commit_valid_i & (rem_next == '0);

  // Done pulse in the grant cycle of the last word
  always_comb begin
    insn_done_o              = '0;
    insn_done_o[commit_id_i] = commit_done_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      loaded_q <= 1'b0;
      rem_q    <= '0;
    end else begin
      if (rq_push_i) wr_pnt_q <= wr_pnt_q + 1'b1;
      if (gnt) rd_pnt_q <= rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + lane_pkg::rq_cnt_t'(rq_push_i) - lane_pkg::rq_cnt_t'(gnt);
      if (gnt) begin
        loaded_q <= !commit_done_o;
        rem_q    <= rem_next;
      end
    end
  end

endmodule

// File: src/valu_issue.sv
module valu_issue (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Issue instruction
  input  logic              issue_valid_i,
  input  rvv_pkg::alu_op_e  issue_op_i,
  input  rvv_pkg::vew_e     issue_vsew_i,
  input  lane_pkg::vlen_t   issue_vl_i,
  input  lane_pkg::vreg_t   issue_vd_i,
  input  rvv_pkg::vid_t     issue_id_i,
  input  logic              issue_vm_i,
  input  logic              issue_use_scalar_i,
  input  lane_pkg::elen_t   issue_scalar_i,
  output logic              issue_done_o,
  // Operand queues, bit 1 is vs2 and bit 0 is vs1
  input  lane_pkg::elen_t   operand_a_i,
  input  lane_pkg::elen_t   operand_b_i,
  input  logic [1:0]        operand_valid_i,
  output logic [1:0]        operand_ready_o,
  input  lane_pkg::strb_t   mask_i,
  input  logic              mask_valid_i,
  output logic              mask_ready_o,
  // Result queue write
  input  logic              rq_full_i,
  output logic              rq_push_o,
  output rvv_pkg::vid_t     rq_id_o,
  output lane_pkg::vaddr_t  rq_addr_o,
  output lane_pkg::elen_t   rq_wdata_o,
  output lane_pkg::strb_t   rq_be_o
);

  // Remaining elements, valid once the first word has gone out
  lane_pkg::vlen_t rem_q;
  logic            loaded_q;
  lane_pkg::vlen_t remaining;
  lane_pkg::vlen_t elem_per_word;
  lane_pkg::vlen_t elem_cnt;
  lane_pkg::vlen_t elem_done;
  logic [1:0]      log_epw;
  lane_pkg::strb_t count_be;
  lane_pkg::elen_t scalar_rep;
  logic            fire;

  //////////////////////////////////////////////////////////////////////////
  // Element counting
  //////////////////////////////////////////////////////////////////////////

  // First word of a new instruction counts from its full vl
  assign remaining     = loaded_q ? rem_q : issue_vl_i;
  // log2 of elements per word, 3 for bytes down to 0 for doublewords
  assign log_epw       = 2'd3 - issue_vsew_i;
  assign elem_per_word = lane_pkg::vlen_t'(1) << log_epw;
  assign elem_cnt      = (elem_per_word < remaining) ? elem_per_word : remaining;
  assign elem_done     = issue_vl_i - remaining;

  // Word needs vs2, vs1 unless scalar, mask unless unmasked, and room
  assign fire = issue_valid_i && !rq_full_i && operand_valid_i[1]
             && (operand_valid_i[0] || issue_use_scalar_i)
             && (mask_valid_i || issue_vm_i);

  assign operand_ready_o = {fire, fire & ~issue_use_scalar_i};
  assign mask_ready_o    = fire & ~issue_vm_i;
  assign issue_done_o    = fire && (remaining == elem_cnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      rem_q    <= '0;
    end else if (fire) begin
      loaded_q <= !issue_done_o;
      rem_q    <= remaining - elem_cnt;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Operands and datapath
  //////////////////////////////////////////////////////////////////////////

  // Low element of the scalar copied into every element slot
  always_comb begin
    unique case (issue_vsew_i)
      rvv_pkg::EW8:  scalar_rep = {8{issue_scalar_i[7:0]}};
      rvv_pkg::EW16: scalar_rep = {4{issue_scalar_i[15:0]}};
      rvv_pkg::EW32: scalar_rep = {2{issue_scalar_i[31:0]}};
      default:       scalar_rep = issue_scalar_i;
    endcase
  end

  valu_simd_alu i_simd_alu (
    .operand_a_i (issue_use_scalar_i ? scalar_rep : operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (issue_op_i),
    .vew_i       (issue_vsew_i),
    .result_o    (rq_wdata_o)
  );

  //////////////////////////////////////////////////////////////////////////
  // Byte enables and address
  //////////////////////////////////////////////////////////////////////////

  // Byte b belongs to element b >> vsew, enabled up to the count
  always_comb begin
    for (int b = 0; b < lane_pkg::StrbBits; b++) begin
      count_be[b] = (lane_pkg::vlen_t'(b) >> issue_vsew_i) < elem_cnt;
    end
  end

  assign rq_be_o   = count_be & (issue_vm_i ? '1 : mask_i);
  assign rq_push_o = fire;
  assign rq_id_o   = issue_id_i;
  // Word index is elements already issued over elements per word
  assign rq_addr_o = lane_pkg::vaddr_t'(issue_vd_i) * lane_pkg::vaddr_t'(lane_pkg::VRegWords)
                   + lane_pkg::vaddr_t'(elem_done >> log_epw);

endmodule

// File: src/valu_insn_queue.sv
module valu_insn_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Sequencer side
  input  logic              insn_valid_i,
  output logic              insn_ready_o,
  input  rvv_pkg::alu_op_e  insn_op_i,
  input  rvv_pkg::vew_e     insn_vsew_i,
  input  lane_pkg::vlen_t   insn_vl_i,
  input  lane_pkg::vreg_t   insn_vd_i,
  input  rvv_pkg::vid_t     insn_id_i,
  input  logic              insn_vm_i,
  input  logic              insn_use_scalar_i,
  input  lane_pkg::elen_t   insn_scalar_i,
  // Issue phase
  output logic              issue_valid_o,
  output rvv_pkg::alu_op_e  issue_op_o,
  output rvv_pkg::vew_e     issue_vsew_o,
  output lane_pkg::vlen_t   issue_vl_o,
  output lane_pkg::vreg_t   issue_vd_o,
  output rvv_pkg::vid_t     issue_id_o,
  output logic              issue_vm_o,
  output logic              issue_use_scalar_o,
  output lane_pkg::elen_t   issue_scalar_o,
  input  logic              issue_done_i,
  // Commit phase
  output logic              commit_valid_o,
  output rvv_pkg::vid_t     commit_id_o,
  output lane_pkg::vlen_t   commit_vl_o,
  output rvv_pkg::vew_e     commit_vsew_o,
  input  logic              commit_done_i
);

  // Instruction slots
  rvv_pkg::alu_op_e op_q         [lane_pkg::InsnQueueDepth];
  rvv_pkg::vew_e    vsew_q       [lane_pkg::InsnQueueDepth];
  lane_pkg::vlen_t  vl_q         [lane_pkg::InsnQueueDepth];
  lane_pkg::vreg_t  vd_q         [lane_pkg::InsnQueueDepth];
  rvv_pkg::vid_t    id_q         [lane_pkg::InsnQueueDepth];
  logic             vm_q         [lane_pkg::InsnQueueDepth];
  logic             use_scalar_q [lane_pkg::InsnQueueDepth];
  lane_pkg::elen_t  scalar_q     [lane_pkg::InsnQueueDepth];

  // One pointer per phase, counts of instructions waiting for issue and commit
  lane_pkg::insn_pnt_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  lane_pkg::insn_cnt_t issue_cnt_q, commit_cnt_q;
  logic                accept;

  // A slot is free again only once its results are committed
  assign insn_ready_o = commit_cnt_q != lane_pkg::insn_cnt_t'(lane_pkg::InsnQueueDepth);
  assign accept       = insn_valid_i & insn_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]         <= insn_op_i;
      vsew_q[accept_pnt_q]       <= insn_vsew_i;
      vl_q[accept_pnt_q]         <= insn_vl_i;
      vd_q[accept_pnt_q]         <= insn_vd_i;
      id_q[accept_pnt_q]         <= insn_id_i;
      vm_q[accept_pnt_q]         <= insn_vm_i;
      use_scalar_q[accept_pnt_q] <= insn_use_scalar_i;
      scalar_q[accept_pnt_q]     <= insn_scalar_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      // Depth is a power of two, pointers wrap on their own
      if (accept) accept_pnt_q <= accept_pnt_q + 1'b1;
      if (issue_done_i) issue_pnt_q <= issue_pnt_q + 1'b1;
      if (commit_done_i) commit_pnt_q <= commit_pnt_q + 1'b1;
      issue_cnt_q  <= issue_cnt_q + lane_pkg::insn_cnt_t'(accept)
                    - lane_pkg::insn_cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + lane_pkg::insn_cnt_t'(accept)
                    - lane_pkg::insn_cnt_t'(commit_done_i);
    end
  end

  // Oldest instruction not yet fully issued
  assign issue_valid_o      = issue_cnt_q != '0;
  assign issue_op_o         = op_q[issue_pnt_q];
  assign issue_vsew_o       = vsew_q[issue_pnt_q];
  assign issue_vl_o         = vl_q[issue_pnt_q];
  assign issue_vd_o         = vd_q[issue_pnt_q];
  assign issue_id_o         = id_q[issue_pnt_q];
  assign issue_vm_o         = vm_q[issue_pnt_q];
  assign issue_use_scalar_o = use_scalar_q[issue_pnt_q];
  assign issue_scalar_o     = scalar_q[issue_pnt_q];

  // Oldest instruction with words still to be written back
  assign commit_valid_o = commit_cnt_q != '0;
  assign commit_id_o    = id_q[commit_pnt_q];
  assign commit_vl_o    = vl_q[commit_pnt_q];
  assign commit_vsew_o  = vsew_q[commit_pnt_q];

endmodule

// File: src/valu_simd_alu.sv
module valu_simd_alu (
  input  lane_pkg::elen_t  operand_a_i,
  input  lane_pkg::elen_t  operand_b_i,
  input  rvv_pkg::alu_op_e op_i,
  input  rvv_pkg::vew_e    vew_i,
  output lane_pkg::elen_t  result_o
);

  // One element on zero-extended operands, caller keeps the low bits
  function automatic lane_pkg::elen_t elem_op(lane_pkg::elen_t a, lane_pkg::elen_t b,
                                              rvv_pkg::alu_op_e op);
    unique case (op)
      rvv_pkg::VADD:  elem_op = b + a;
      rvv_pkg::VSUB:  elem_op = b - a;
      rvv_pkg::VRSUB: elem_op = a - b;
      rvv_pkg::VAND:  elem_op = b & a;
      rvv_pkg::VOR:   elem_op = b | a;
      rvv_pkg::VXOR:  elem_op = b ^ a;
      rvv_pkg::VMINU: elem_op = (b < a) ? b : a;
      default:        elem_op = (b > a) ? b : a;
    endcase
  endfunction

  // Each width runs its own lanes, no carry crosses an element boundary
  always_comb begin
    result_o = '0;
    unique case (vew_i)
      rvv_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          result_o[8*i +: 8] = 8'(elem_op(lane_pkg::elen_t'(operand_a_i[8*i +: 8]),
                                          lane_pkg::elen_t'(operand_b_i[8*i +: 8]), op_i));
        end
      end
      rvv_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          result_o[16*i +: 16] = 16'(elem_op(lane_pkg::elen_t'(operand_a_i[16*i +: 16]),
                                             lane_pkg::elen_t'(operand_b_i[16*i +: 16]),
                                             op_i));
        end
      end
      rvv_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          result_o[32*i +: 32] = 32'(elem_op(lane_pkg::elen_t'(operand_a_i[32*i +: 32]),
                                             lane_pkg::elen_t'(operand_b_i[32*i +: 32]),
                                             op_i));
        end
      end
      // Whole word is one element
      default: result_o = elem_op(operand_a_i, operand_b_i, op_i);
    endcase
  end

endmodule

// File: src/lane_pkg.sv
package lane_pkg;

  // Datapath word and its byte strobe
  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;
  typedef logic [ElenBits-1:0] elen_t;
  typedef logic [StrbBits-1:0] strb_t;

  // Element count, 1 to VlMax
  localparam int unsigned VlMax = 32;
  typedef logic [$clog2(VlMax+1)-1:0] vlen_t;

  //////////////////////////////////////////////////////////////////////////
  // Register file slice of this lane
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned NrVRegs   = 32;
  localparam int unsigned VRegWords = 32;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // Word address, register index times VRegWords plus word index
  typedef logic [$clog2(NrVRegs*VRegWords)-1:0] vaddr_t;

  //////////////////////////////////////////////////////////////////////////
  // Queue sizes
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned InsnQueueDepth = 4;
  typedef logic [$clog2(InsnQueueDepth)-1:0] insn_pnt_t;
  typedef logic [$clog2(InsnQueueDepth):0]   insn_cnt_t;

  localparam int unsigned ResultQueueDepth = 2;
  typedef logic [$clog2(ResultQueueDepth)-1:0] rq_pnt_t;
  typedef logic [$clog2(ResultQueueDepth):0]   rq_cnt_t;

endpackage

// File: src/rvv_pkg.sv
package rvv_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////////

  // Integer ops of the lane ALU, all computed as vs2 op vs1
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    // Reverse subtract, vs1 - vs2
    VRSUB,
    VAND,
    VOR,
    VXOR,
    // Unsigned min and max
    VMINU,
    VMAXU
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Element width and instruction ids
  //////////////////////////////////////////////////////////////////////////

  // Encoded as log2 of the element byte size
  typedef enum logic [1:0] {
    EW8  = 2'b00,
    EW16 = 2'b01,
    EW32 = 2'b10,
    EW64 = 2'b11
  } vew_e;

  // Ids handed out by the sequencer, one done bit each
  localparam int unsigned NrVInsn = 8;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

endpackage
